// ==== Makefile ====
# Verilator build and run of the RV32I core testbench

TOP       ?= tb_rv_core
LOG       ?= sim.log
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
OBJ_DIR   ?= obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, check $(LOG)"
	@echo "  clean  remove build output and log"
	@echo "variables: TOP LOG VERILATOR VFLAGS OBJ_DIR"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f files.f
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Finished with errors" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "Finished with no errors" $(LOG) || { echo "simulation incomplete"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== cpu_cfg_pkg.sv ====
package cpu_cfg_pkg;

	localparam int unsigned xlen       = 32;
	localparam logic [xlen-1:0] reset_pc = 32'h0000_0000; // first fetch address
	localparam int unsigned reg_addr_w = 5;

	// prefetch queue between fetch and execute
	localparam int unsigned buf_depth  = 2;
	localparam int unsigned buf_ptr_w  = $clog2(buf_depth);
	localparam int unsigned buf_cnt_w  = $clog2(buf_depth + 1);

	// execute sequencer states
	localparam logic [1:0] st_idle      = 2'd0;
	localparam logic [1:0] st_load_wait = 2'd1; // data word returns this cycle
	localparam logic [1:0] st_halted    = 2'd2;

endpackage

// ==== exec_unit.sv ====
`timescale 1ns/10ps

module exec_unit import cpu_cfg_pkg::*, rv_isa_pkg::*; (
	input  logic              clk,
	input  logic              reset_i,
	input  logic              head_valid_i,
	input  logic [xlen-1:0]   head_pc_i,
	input  logic [xlen-1:0]   head_inst_i,
	output logic              pop_o,
	output logic              redirect_o,
	output logic [xlen-1:0]   target_o,
	output logic              mem_ren_o,
	output logic              mem_wen_o,
	output logic [xlen-1:0]   mem_addr_o,
	output logic [xlen-1:0]   mem_wdata_o,
	output logic [xlen/8-1:0] mem_wmask_o,
	input  logic [xlen-1:0]   mem_rdata_i,
	output logic [xlen-1:0]   pc_o,
	output logic              invalid_o,
	output logic              finish_o
);

	rv_inst_u              inst;
	logic [6:0]            opcode;
	logic [2:0]            funct3;
	logic [6:0]            funct7;
	logic [reg_addr_w-1:0] rd;
	logic [reg_addr_w-1:0] rs1;
	logic [reg_addr_w-1:0] rs2;
	logic [xlen-1:0]       imm_i;
	logic [xlen-1:0]       imm_s;
	logic [xlen-1:0]       imm_b;
	logic [xlen-1:0]       imm_u;
	logic [xlen-1:0]       imm_j;
	logic [xlen-1:0]       imm;
	logic [xlen-1:0]       rdata1;
	logic [xlen-1:0]       rdata2;
	logic [xlen-1:0]       op_b;
	logic [xlen-1:0]       alu_res;
	logic [xlen-1:0]       wb_data;
	logic [xlen-1:0]       last_pc_q;
	logic [1:0]            state_q;
	alu_op_e               alu_op;
	logic                  use_imm;
	logic                  reg_wen_dec;
	logic                  is_load;
	logic                  is_store;
	logic                  is_branch;
	logic                  is_jal;
	logic                  is_halt;
	logic                  illegal;
	logic                  taken;
	logic                  active;
	logic                  idle_go;
	logic                  retire;

	assign inst   = head_inst_i;
	assign opcode = inst.r_fmt.opcode;
	assign funct3 = inst.r_fmt.funct3;
	assign funct7 = inst.r_fmt.funct7;
	assign rd     = inst.r_fmt.rd;
	assign rs1    = inst.r_fmt.rs1;
	assign rs2    = inst.r_fmt.rs2;

	assign imm_i = {{20{inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
	assign imm_s = {{20{inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};
	assign imm_b = {{19{inst.b_fmt.imm12}}, inst.b_fmt.imm12, inst.b_fmt.imm11,
		inst.b_fmt.imm10_5, inst.b_fmt.imm4_1, 1'b0};
	assign imm_u = {inst.u_fmt.imm, 12'b0};
	assign imm_j = {{11{inst.j_fmt.imm20}}, inst.j_fmt.imm20, inst.j_fmt.imm19_12,
		inst.j_fmt.imm11, inst.j_fmt.imm10_1, 1'b0};

	always_comb begin
		alu_op      = alu_add;
		use_imm     = 1'b1;
		imm         = imm_i;
		reg_wen_dec = 1'b0;
		is_load     = 1'b0;
		is_store    = 1'b0;
		is_branch   = 1'b0;
		is_jal      = 1'b0;
		is_halt     = 1'b0;
		illegal     = 1'b0;
		case (opcode)
			op_lui: begin
				alu_op      = alu_pass_b;
				imm         = imm_u;
				reg_wen_dec = 1'b1;
			end
			op_opimm: begin
				if (funct3 == f3_add) reg_wen_dec = 1'b1;
				else illegal = 1'b1;
			end
			op_op: begin
				use_imm     = 1'b0;
				reg_wen_dec = 1'b1;
				case ({funct7, funct3})
					{f7_base, f3_add}: alu_op = alu_add;
					{f7_sub, f3_add}:  alu_op = alu_sub;
					{f7_base, f3_and}: alu_op = alu_and;
					{f7_base, f3_or}:  alu_op = alu_or;
					default: begin
						reg_wen_dec = 1'b0;
						illegal     = 1'b1;
					end
				endcase
			end
			op_load: begin
				is_load     = funct3 == f3_lw;
				reg_wen_dec = funct3 == f3_lw;
				illegal     = funct3 != f3_lw; // byte and half loads unsupported
			end
			op_store: begin
				imm      = imm_s;
				is_store = funct3 == f3_sw;
				illegal  = funct3 != f3_sw;
			end
			op_branch: begin
				is_branch = funct3 == f3_beq || funct3 == f3_bne;
				illegal   = !(funct3 == f3_beq || funct3 == f3_bne);
			end
			op_jal: begin
				is_jal      = 1'b1;
				reg_wen_dec = 1'b1;
			end
			op_system: begin
				is_halt = head_inst_i == inst_ebreak;
				illegal = head_inst_i != inst_ebreak;
			end
			default: illegal = 1'b1;
		endcase
	end

	assign op_b = use_imm ? imm : rdata2;

	always_comb begin
		case (alu_op)
			alu_add:    alu_res = rdata1 + op_b;
			alu_sub:    alu_res = rdata1 - op_b;
			alu_and:    alu_res = rdata1 & op_b;
			alu_or:     alu_res = rdata1 | op_b;
			alu_pass_b: alu_res = op_b;
			default:    alu_res = '0;
		endcase
	end

	// beq and bne share one compare
	assign taken    = is_jal | (is_branch & ((funct3 == f3_beq) == (rdata1 == rdata2)));
	assign target_o = head_pc_i + (is_jal ? imm_j : imm_b);

	assign active  = head_valid_i & (state_q != st_halted);
	assign idle_go = head_valid_i & (state_q == st_idle);
	assign retire  = (idle_go & ~is_load) | (head_valid_i & (state_q == st_load_wait));

	assign pop_o       = retire;
	assign redirect_o  = idle_go & taken;
	assign invalid_o   = idle_go & illegal; // retires as a no-op
	assign mem_ren_o   = idle_go & is_load;
	assign mem_wen_o   = idle_go & is_store;
	assign mem_addr_o  = alu_res;
	assign mem_wdata_o = rdata2;
	assign mem_wmask_o = '1;               // word accesses only
	assign finish_o    = state_q == st_halted;
	assign pc_o        = active ? head_pc_i : last_pc_q;

	assign wb_data = is_jal ? head_pc_i + xlen'(4) : (is_load ? mem_rdata_i : alu_res);

	always_ff @(posedge clk) begin
		if (reset_i) begin
			state_q   <= st_idle;
			last_pc_q <= reset_pc;
		end else begin
			if (active) last_pc_q <= head_pc_i;
			case (state_q)
				st_idle: begin
					if (head_valid_i & is_halt) state_q <= st_halted;
					else if (head_valid_i & is_load) state_q <= st_load_wait;
				end
				st_load_wait: state_q <= st_idle;
				default:      state_q <= state_q; // halted until reset
			endcase
		end
	end

	reg_file u_reg_file (
		.clk      (clk),
		.reset_i  (reset_i),
		.raddr1_i (rs1),
		.raddr2_i (rs2),
		.rdata1_o (rdata1),
		.rdata2_o (rdata2),
		.wen_i    (retire & reg_wen_dec),
		.waddr_i  (rd),
		.wdata_i  (wb_data)
	);

endmodule

// ==== fetch_if.sv ====
`timescale 1ns/10ps

interface fetch_if import cpu_cfg_pkg::*; ();

	logic            valid;    // one-cycle strobe per returned word
	logic [xlen-1:0] pc;
	logic [xlen-1:0] inst;
	logic            busy;     // a read is in flight
	logic            credit;   // room for one more word
	logic            redirect; // flush from execute
	logic [xlen-1:0] target;

	modport fetch (
		output valid, pc, inst, busy,
		input  credit, redirect, target
	);

	modport buffer (
		input  valid, pc, inst, busy, redirect,
		output credit
	);

endinterface

// ==== fetch_unit.sv ====
`timescale 1ns/10ps

module fetch_unit import cpu_cfg_pkg::*; (
	input  logic            clk,
	input  logic            reset_i,
	fetch_if.fetch          fb,
	input  logic            finish_i,
	output logic            inst_ren_o,
	output logic [xlen-1:0] inst_addr_o,
	input  logic [xlen-1:0] inst_i
);

	logic [xlen-1:0] pc_q;
	logic [xlen-1:0] req_pc_q; // pc of the word in flight
	logic            run_q;
	logic            busy_q;
	logic            drop_q;
	logic            issue;

	// one read per cycle while the buffer has room
	assign issue = run_q & fb.credit & ~finish_i;

	assign inst_ren_o  = issue;
	assign inst_addr_o = pc_q;

	// returned word goes straight into the buffer
	assign fb.valid = busy_q & ~drop_q;
	assign fb.pc    = req_pc_q;
	assign fb.inst  = inst_i;
	assign fb.busy  = busy_q;

	always_ff @(posedge clk) begin
		if (reset_i) begin
			run_q  <= 1'b0;
			busy_q <= 1'b0;
			drop_q <= 1'b0;
			pc_q   <= reset_pc;
		end else begin
			run_q  <= 1'b1; // first read one cycle out of reset
			busy_q <= issue;
			// a read issued during a redirect fetches the old path
			drop_q <= issue & fb.redirect;
			if (fb.redirect) begin
				pc_q <= fb.target;
			end else if (issue) begin
				pc_q <= pc_q + xlen'(4);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (issue) begin
			req_pc_q <= pc_q;
		end
	end

endmodule

// ==== files.f ====
cpu_cfg_pkg.sv
rv_isa_pkg.sv
fetch_if.sv
fetch_unit.sv
inst_buffer.sv
reg_file.sv
exec_unit.sv
rv_core.sv
tb_clock_gen.sv
tb_mem_model.sv
tb_rv_core.sv

// ==== inst_buffer.sv ====
`timescale 1ns/10ps

module inst_buffer import cpu_cfg_pkg::*; (
	input  logic            clk,
	input  logic            reset_i,
	fetch_if.buffer         fb,
	output logic            head_valid_o,
	output logic [xlen-1:0] head_pc_o,
	output logic [xlen-1:0] head_inst_o,
	input  logic            pop_i
);

	logic [xlen-1:0]      pc_mem   [buf_depth];
	logic [xlen-1:0]      inst_mem [buf_depth];
	logic [buf_ptr_w-1:0] wr_ptr_q;
	logic [buf_ptr_w-1:0] rd_ptr_q;
	logic [buf_cnt_w-1:0] count_q;
	logic [buf_cnt_w:0]   used;  // stored plus in flight
	logic                 wr;
	logic                 rd;

	assign wr = fb.valid & ~fb.redirect; // flush wins over a late word
	assign rd = pop_i & head_valid_o;

	assign used      = {1'b0, count_q} + (buf_cnt_w + 1)'(fb.busy);
	assign fb.credit = used < (buf_cnt_w + 1)'(buf_depth);

	assign head_valid_o = count_q != '0;
	assign head_pc_o    = pc_mem[rd_ptr_q];
	assign head_inst_o  = inst_mem[rd_ptr_q];

	always_ff @(posedge clk) begin
		if (reset_i || fb.redirect) begin
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q  <= '0;
		end else begin
			if (wr) wr_ptr_q <= wr_ptr_q + buf_ptr_w'(1);
			if (rd) rd_ptr_q <= rd_ptr_q + buf_ptr_w'(1);
			case ({wr, rd})
				2'b10:   count_q <= count_q + buf_cnt_w'(1);
				2'b01:   count_q <= count_q - buf_cnt_w'(1);
				default: count_q <= count_q;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (wr) begin
			pc_mem[wr_ptr_q]   <= fb.pc;
			inst_mem[wr_ptr_q] <= fb.inst;
		end
	end

endmodule

// ==== program.hex ====
// one instruction word per line, hex, from address 0
// byte address and assembly in the comment
123450B7 // 00 lui  x1, 0x12345
10000113 // 04 addi x2, x0, 0x100
00112023 // 08 sw   x1, 0(x2)
67808193 // 0c addi x3, x1, 0x678
00312223 // 10 sw   x3, 4(x2)
0F000213 // 14 addi x4, x0, 0xf0
004182B3 // 18 add  x5, x3, x4
00512423 // 1c sw   x5, 8(x2)
40418333 // 20 sub  x6, x3, x4
00612623 // 24 sw   x6, 12(x2)
0041F3B3 // 28 and  x7, x3, x4
00712823 // 2c sw   x7, 16(x2)
0041E433 // 30 or   x8, x3, x4
00812A23 // 34 sw   x8, 20(x2)
04002483 // 38 lw   x9, 0x40(x0)
00548493 // 3c addi x9, x9, 5
00912C23 // 40 sw   x9, 24(x2)
00700013 // 44 addi x0, x0, 7
00012E23 // 48 sw   x0, 28(x2)
00000463 // 4c beq  x0, x0, +8
06102E23 // 50 sw   x1, 0x7c(x0) skipped
00001463 // 54 bne  x0, x0, +8 not taken
02412023 // 58 sw   x4, 32(x2)
0080056F // 5c jal  x10, +8
06102E23 // 60 sw   x1, 0x7c(x0) skipped
02A12223 // 64 sw   x10, 36(x2)
FFFFFFFF // 68 illegal
02312423 // 6c sw   x3, 40(x2)
00100073 // 70 ebreak

// ==== reg_file.sv ====
`timescale 1ns/10ps

module reg_file import cpu_cfg_pkg::*; (
	input  logic                  clk,
	input  logic                  reset_i,
	input  logic [reg_addr_w-1:0] raddr1_i,
	input  logic [reg_addr_w-1:0] raddr2_i,
	output logic [xlen-1:0]       rdata1_o,
	output logic [xlen-1:0]       rdata2_o,
	input  logic                  wen_i,
	input  logic [reg_addr_w-1:0] waddr_i,
	input  logic [xlen-1:0]       wdata_i
);

	logic [xlen-1:0] regs [2**reg_addr_w];

	assign rdata1_o = regs[raddr1_i];
	assign rdata2_o = regs[raddr2_i];

	always_ff @(posedge clk) begin
		if (reset_i) begin
			for (int i = 0; i < 2**reg_addr_w; i++) begin
				regs[i] <= '0;
			end
		end else if (wen_i && waddr_i != '0) begin // x0 never written
			regs[waddr_i] <= wdata_i;
		end
	end

endmodule

// ==== rv_core.sv ====
`timescale 1ns/10ps

module rv_core import cpu_cfg_pkg::*; (
	input  logic              clk,
	input  logic              reset_i,
	output logic              inst_ren_o,
	output logic [xlen-1:0]   inst_addr_o,
	input  logic [xlen-1:0]   inst_i,
	output logic              mem_ren_o,
	output logic              mem_wen_o,
	output logic [xlen-1:0]   mem_addr_o,
	output logic [xlen-1:0]   mem_wdata_o,
	output logic [xlen/8-1:0] mem_wmask_o,
	input  logic [xlen-1:0]   mem_rdata_i,
	output logic [xlen-1:0]   pc_o,
	output logic              invalid_o,
	output logic              finish_o
);

	logic            head_valid;
	logic [xlen-1:0] head_pc;
	logic [xlen-1:0] head_inst;
	logic            pop;
	logic            redirect;
	logic [xlen-1:0] target;

	fetch_if fb ();

	// fetch and buffer see the same flush
	assign fb.redirect = redirect;
	assign fb.target   = target;

	fetch_unit u_fetch_unit (
		.clk         (clk),
		.reset_i     (reset_i),
		.fb          (fb.fetch),
		.finish_i    (finish_o),
		.inst_ren_o  (inst_ren_o),
		.inst_addr_o (inst_addr_o),
		.inst_i      (inst_i)
	);

	inst_buffer u_inst_buffer (
		.clk          (clk),
		.reset_i      (reset_i),
		.fb           (fb.buffer),
		.head_valid_o (head_valid),
		.head_pc_o    (head_pc),
		.head_inst_o  (head_inst),
		.pop_i        (pop)
	);

	exec_unit u_exec_unit (
		.clk          (clk),
		.reset_i      (reset_i),
		.head_valid_i (head_valid),
		.head_pc_i    (head_pc),
		.head_inst_i  (head_inst),
		.pop_o        (pop),
		.redirect_o   (redirect),
		.target_o     (target),
		.mem_ren_o    (mem_ren_o),
		.mem_wen_o    (mem_wen_o),
		.mem_addr_o   (mem_addr_o),
		.mem_wdata_o  (mem_wdata_o),
		.mem_wmask_o  (mem_wmask_o),
		.mem_rdata_i  (mem_rdata_i),
		.pc_o         (pc_o),
		.invalid_o    (invalid_o),
		.finish_o     (finish_o)
	);

endmodule

// ==== rv_isa_pkg.sv ====
package rv_isa_pkg;

	// major opcodes
	localparam logic [6:0] op_lui    = 7'b0110111;
	localparam logic [6:0] op_opimm  = 7'b0010011;
	localparam logic [6:0] op_op     = 7'b0110011;
	localparam logic [6:0] op_load   = 7'b0000011;
	localparam logic [6:0] op_store  = 7'b0100011;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_jal    = 7'b1101111;
	localparam logic [6:0] op_system = 7'b1110011;

	localparam logic [2:0] f3_add = 3'b000; // addi, add, sub
	localparam logic [2:0] f3_and = 3'b111;
	localparam logic [2:0] f3_or  = 3'b110;
	localparam logic [2:0] f3_lw  = 3'b010;
	localparam logic [2:0] f3_sw  = 3'b010;
	localparam logic [2:0] f3_beq = 3'b000;
	localparam logic [2:0] f3_bne = 3'b001;

	localparam logic [6:0] f7_base = 7'b0000000;
	localparam logic [6:0] f7_sub  = 7'b0100000;

	localparam logic [31:0] inst_ebreak = 32'h0010_0073;

	typedef enum logic [2:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_pass_b  // lui
	} alu_op_e;

	typedef struct packed {
		logic [6:0] funct7;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] rd;
		logic [6:0] opcode;
	} r_fmt_t;

	typedef struct packed {
		logic [11:0] imm;
		logic [4:0]  rs1;
		logic [2:0]  funct3;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} i_fmt_t;

	typedef struct packed {
		logic [6:0] imm_hi;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [4:0] imm_lo;
		logic [6:0] opcode;
	} s_fmt_t;

	// branch offset bits are scattered, bit 0 is implied
	typedef struct packed {
		logic       imm12;
		logic [5:0] imm10_5;
		logic [4:0] rs2;
		logic [4:0] rs1;
		logic [2:0] funct3;
		logic [3:0] imm4_1;
		logic       imm11;
		logic [6:0] opcode;
	} b_fmt_t;

	typedef struct packed {
		logic [19:0] imm;
		logic [4:0]  rd;
		logic [6:0]  opcode;
	} u_fmt_t;

	typedef struct packed {
		logic       imm20;
		logic [9:0] imm10_1;
		logic       imm11;
		logic [7:0] imm19_12;
		logic [4:0] rd;
		logic [6:0] opcode;
	} j_fmt_t;

	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		s_fmt_t s_fmt;
		b_fmt_t b_fmt;
		u_fmt_t u_fmt;
		j_fmt_t j_fmt;
	} rv_inst_u;

endpackage

// ==== tb_clock_gen.sv ====
`timescale 1ns/10ps

module tb_clock_gen (
	output logic clk_o,
	output logic reset_o
);

	localparam realtime half_period = 10ns; // 20 ns clock
	localparam int      reset_cycles = 3;

	initial begin
		clk_o = 1'b0;
		forever #(half_period) clk_o = ~clk_o;
	end

	// reset released on a falling edge like all other stimulus
	initial begin
		reset_o = 1'b1;
		repeat (reset_cycles) @(posedge clk_o);
		@(negedge clk_o);
		reset_o = 1'b0;
	end

endmodule

// ==== tb_mem_model.sv ====
`timescale 1ns/10ps

module tb_mem_model (
	input  logic        clk,
	input  logic        inst_ren_i,
	input  logic [31:0] inst_addr_i,
	output logic [31:0] inst_o,
	input  logic        mem_ren_i,
	input  logic        mem_wen_i,
	input  logic [31:0] mem_addr_i,
	input  logic [31:0] mem_wdata_i,
	input  logic [3:0]  mem_wmask_i,
	output logic [31:0] mem_rdata_o
);

	logic [31:0] rom [64];
	logic [31:0] ram [128];
	logic [5:0]  rom_idx_q;
	logic [6:0]  ram_idx_q;
	logic        inst_pend_q;
	logic        data_pend_q;
	int          seed;

	initial begin
		seed = 62193; // same sequence as the testbench copy
		for (int i = 0; i < 64; i++) begin
			rom[i] = 32'h0;
		end
		$readmemh("program.hex", rom);
		for (int i = 0; i < 128; i++) begin
			ram[i] = $random(seed);
		end
		inst_o      = 32'h0;
		mem_rdata_o = 32'h0;
	end

	// requests sampled on the rising edge
	always @(posedge clk) begin
		inst_pend_q <= inst_ren_i;
		data_pend_q <= mem_ren_i;
		if (inst_ren_i) rom_idx_q <= inst_addr_i[7:2];
		if (mem_ren_i) ram_idx_q <= mem_addr_i[8:2];
	end

	// stores take effect at the rising edge
	always @(posedge clk) begin
		if (mem_wen_i) begin
			for (int b = 0; b < 4; b++) begin
				if (mem_wmask_i[b]) ram[mem_addr_i[8:2]][8*b +: 8] = mem_wdata_i[8*b +: 8];
			end
		end
	end

	// read data driven half a cycle later
	always @(negedge clk) begin
		if (inst_pend_q) inst_o = rom[rom_idx_q];
		if (data_pend_q) mem_rdata_o = ram[ram_idx_q];
	end

endmodule

// ==== tb_rv_core.sv ====
`timescale 1ns/10ps

module tb_rv_core;

	localparam int          n_stores   = 11;
	localparam int          prog_len   = 40;  // instruction count rounded up
	localparam int          worst_cpi  = 2;   // lw
	localparam int          flush_slack = 20; // refetch after redirects
	localparam int          max_cycles = (prog_len * worst_cpi + flush_slack) * 4;
	localparam logic [31:0] poison_addr = 32'h0000_007c;
	localparam logic [31:0] load_addr   = 32'h0000_0040;
	localparam logic [31:0] bad_pc      = 32'h0000_0068; // 0xffffffff word
	localparam logic [31:0] beq_target  = 32'h0000_0054; // beq at 0x4c plus 8
	localparam logic [31:0] jal_target  = 32'h0000_0064; // jal at 0x5c plus 8
	localparam int          load_store  = 6;
	localparam int          after_bad   = 10;

	logic        clk;
	logic        reset;
	logic        inst_ren;
	logic [31:0] inst_addr;
	logic [31:0] inst;
	logic        mem_ren;
	logic        mem_wen;
	logic [31:0] mem_addr;
	logic [31:0] mem_wdata;
	logic [3:0]  mem_wmask;
	logic [31:0] mem_rdata;
	logic [31:0] pc;
	logic        invalid;
	logic        finish;

	logic [31:0] ram_copy [128];
	logic [31:0] exp_addr [n_stores];
	logic [31:0] exp_data [n_stores];
	logic [31:0] x1;
	logic [31:0] x3;
	logic [31:0] x4;
	logic [31:0] next_fetch;
	int          seed;
	int          errors;
	int          store_cnt;
	int          invalid_cnt;
	bit          load_seen;
	bit          wb_slot;

	tb_clock_gen i_clock_gen (
		.clk_o   (clk),
		.reset_o (reset)
	);

	tb_mem_model i_mem (
		.clk         (clk),
		.inst_ren_i  (inst_ren),
		.inst_addr_i (inst_addr),
		.inst_o      (inst),
		.mem_ren_i   (mem_ren),
		.mem_wen_i   (mem_wen),
		.mem_addr_i  (mem_addr),
		.mem_wdata_i (mem_wdata),
		.mem_wmask_i (mem_wmask),
		.mem_rdata_o (mem_rdata)
	);

	rv_core i_rv_core (
		.clk         (clk),
		.reset_i     (reset),
		.inst_ren_o  (inst_ren),
		.inst_addr_o (inst_addr),
		.inst_i      (inst),
		.mem_ren_o   (mem_ren),
		.mem_wen_o   (mem_wen),
		.mem_addr_o  (mem_addr),
		.mem_wdata_o (mem_wdata),
		.mem_wmask_o (mem_wmask),
		.mem_rdata_i (mem_rdata),
		.pc_o        (pc),
		.invalid_o   (invalid),
		.finish_o    (finish)
	);

	// expected stores for the program in program.hex
	initial begin
		seed = 62193;
		for (int i = 0; i < 128; i++) begin
			ram_copy[i] = $random(seed);
		end
		x1 = 32'h12345 << 12;   // lui
		x3 = x1 + 32'h678;      // addi
		x4 = 32'h0f0;
		for (int i = 0; i < n_stores; i++) begin
			exp_addr[i] = 32'h100 + 32'(4 * i); // x2 base plus offsets
		end
		exp_data[0]  = x1;
		exp_data[1]  = x3;
		exp_data[2]  = x3 + x4;
		exp_data[3]  = x3 - x4;
		exp_data[4]  = x3 & x4;
		exp_data[5]  = x3 | x4;
		exp_data[6]  = ram_copy[load_addr[8:2]] + 32'd5;
		exp_data[7]  = 32'h0;   // x0 stays zero
		exp_data[8]  = x4;      // bne fell through
		exp_data[9]  = 32'h5c + 32'd4; // jal link
		exp_data[10] = x3;
		errors      = 0;
		store_cnt   = 0;
		invalid_cnt = 0;
	end

	always @(posedge clk) begin
		if (reset) begin
			wb_slot    <= 1'b0;
			load_seen  <= 1'b0;
			next_fetch <= 32'h0;
		end else begin
			wb_slot <= mem_ren;
			if (inst_ren) begin
				next_fetch <= inst_addr + 32'd4;
				assert (inst_addr == next_fetch || inst_addr == beq_target ||
					inst_addr == jal_target) else begin
					errors++;
					$display("Error %0t: fetch from %h, expected %h", $time, inst_addr,
						next_fetch);
				end
			end
			if (wb_slot) begin
				assert (!mem_ren && !mem_wen) else begin
					errors++;
					$display("Error %0t: memory access in load write-back cycle", $time);
				end
			end
			if (mem_ren) begin
				load_seen <= 1'b1;
				assert (mem_addr == load_addr) else begin
					errors++;
					$display("Error %0t: load address %h, expected %h", $time, mem_addr,
						load_addr);
				end
			end
			if (invalid) begin
				invalid_cnt++;
				assert (pc == bad_pc) else begin
					errors++;
					$display("Error %0t: invalid_o with pc %h, expected %h", $time, pc, bad_pc);
				end
			end
			if (mem_wen) begin
				assert (mem_addr != poison_addr) else begin
					errors++;
					$display("Error %0t: store to skipped address %h", $time, mem_addr);
				end
				assert (store_cnt < n_stores) else begin
					errors++;
					$display("Error %0t: extra store to %h", $time, mem_addr);
				end
				if (store_cnt < n_stores) begin
					assert (mem_addr == exp_addr[store_cnt] && mem_wdata == exp_data[store_cnt])
					else begin
						errors++;
						$display("Error %0t: store %0d wrote %h to %h, expected %h to %h", $time,
							store_cnt, mem_wdata, mem_addr, exp_data[store_cnt],
							exp_addr[store_cnt]);
					end
					assert (mem_wmask == 4'hf) else begin
						errors++;
						$display("Error %0t: write mask %h, expected f", $time, mem_wmask);
					end
				end
				if (store_cnt == load_store) begin
					assert (load_seen) else begin
						errors++;
						$display("Error %0t: loaded value stored before any load", $time);
					end
				end
				if (store_cnt == after_bad) begin
					assert (invalid_cnt == 1) else begin
						errors++;
						$display("Error %0t: %0d invalid pulses before last store", $time,
							invalid_cnt);
					end
				end
				store_cnt++;
			end
			if (finish) begin
				assert (!inst_ren && !mem_wen) else begin
					errors++;
					$display("Error %0t: fetch or store after finish_o", $time);
				end
			end
		end
	end

	initial begin
		@(negedge reset);
		wait (finish);
		repeat (10) @(posedge clk); // let any stray access show up
		assert (store_cnt == n_stores) else begin
			errors++;
			$display("Error %0t: %0d stores, expected %0d", $time, store_cnt, n_stores);
		end
		assert (invalid_cnt == 1) else begin
			errors++;
			$display("Error %0t: %0d invalid pulses, expected 1", $time, invalid_cnt);
		end
		$display("stores %0d, errors %0d", store_cnt, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	// watchdog
	initial begin
		repeat (max_cycles) @(posedge clk);
		errors++;
		$display("timeout: program never finished within %0d cycles", max_cycles);
		$display("stores %0d, errors %0d", store_cnt, errors);
		$display("Finished with errors");
		$finish;
	end

endmodule
